// ==== lif_neuron.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module lif_neuron
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_sim_restart,
    input  neuro_pkg::sample_t        i_sample,
    input  logic                      i_sample_valid,
    input  logic                      i_ext_spike,
    input  logic [`NEURO_PARAM_W-1:0] i_gain,
    input  logic [`NEURO_PARAM_W-1:0] i_syn_weight,
    input  logic [`NEURO_PARAM_W-1:0] i_threshold,
    output logic                      o_spike
);
    logic [`NEURO_SAMPLE_W+`NEURO_PARAM_W-1:0] product;
    logic [`NEURO_V_W-1:0]                     current;
    logic [`NEURO_V_W-1:0]                     syn_term;
    logic [`NEURO_V_W-1:0]                     membrane;
    logic [`NEURO_V_W-1:0]                     v_next;

    //////////////////////////////////////////////////////////////////////
    // synapse
    //////////////////////////////////////////////////////////////////////
    // gain is 8.8 fixed point
    assign product  = i_sample * i_gain;
    assign current  = product[`NEURO_V_W+7:8];
    // synaptic kick only while the external line is high
    assign syn_term = i_ext_spike ? i_syn_weight : '0;

    //////////////////////////////////////////////////////////////////////
    // membrane
    //////////////////////////////////////////////////////////////////////
    // leak then integrate
    assign v_next = membrane - (membrane >> `NEURO_LEAK_SHIFT) + current + syn_term;

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_sim_restart)
        begin
            membrane <= '0;
            o_spike  <= 1'b0;
        end
        else if (i_sample_valid)
        begin
            // fire and reset at threshold
            if (v_next >= i_threshold)
            begin
                membrane <= '0;
                o_spike  <= 1'b1;
            end
            else
            begin
                membrane <= v_next;
                o_spike  <= 1'b0;
            end
        end
        else
            o_spike <= 1'b0;
    end

endmodule

// ==== list.f ====
+incdir+.
neuro_pkg.sv
param_bank.sv
pipe_loader.sv
wave_player.sv
wave_mem_arbiter.sv
lif_neuron.sv
spike_counter.sv
neuro_top.sv
tb_neuro.sv

// ==== neuro_pkg.sv ====
`include "neuro_settings.svh"

package neuro_pkg;

    // host write target select
    typedef enum logic [2:0]
    {
        PARAM_TICK_DIV   = 3'd0,
        PARAM_GAIN       = 3'd1,
        PARAM_THRESHOLD  = 3'd2,
        PARAM_BLK_SIZE   = 3'd3,
        PARAM_SYN_WEIGHT = 3'd4
    } param_id_e;

    // who held the memory port last cycle
    typedef enum logic [1:0]
    {
        OWN_NONE   = 2'd0,
        OWN_PLAYER = 2'd1,
        OWN_LOADER = 2'd2
    } arb_owner_e;

    // loader: idle or holding a stalled word
    typedef enum logic
    {
        LOAD_IDLE  = 1'b0,
        LOAD_WRITE = 1'b1
    } load_state_e;

    typedef logic [`NEURO_SAMPLE_W-1:0] sample_t;
    typedef logic [`NEURO_CNT_W-1:0]    count_t;

endpackage

// ==== neuro_settings.svh ====
`ifndef NEURO_SETTINGS_SVH
`define NEURO_SETTINGS_SVH

// datapath widths
`define NEURO_SAMPLE_W     16
`define NEURO_MEM_DEPTH    64
`define NEURO_ADDR_W       6
`define NEURO_PARAM_W      32
`define NEURO_CNT_W        32
`define NEURO_V_W          32
// leak is v >> 4 per sample
`define NEURO_LEAK_SHIFT   4

// parameter register defaults after reset
`define NEURO_DEF_TICK_DIV    32'd8
// gain of 256 is unity after the >> 8
`define NEURO_DEF_GAIN        32'd256
`define NEURO_DEF_THRESHOLD   32'd4000
`define NEURO_DEF_BLK_SIZE    32'd64
`define NEURO_DEF_SYN_WEIGHT  32'd0

`endif

// ==== neuro_top.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module neuro_top
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_sim_restart,
    input  logic                      i_param_we,
    input  neuro_pkg::param_id_e      i_param_id,
    input  logic [`NEURO_PARAM_W-1:0] i_param_data,
    input  logic                      i_pipe_valid,
    input  neuro_pkg::sample_t        i_pipe_data,
    output logic                      o_pipe_ready,
    input  logic                      i_ext_spike,
    output neuro_pkg::sample_t        o_wave_sample,
    output logic                      o_wave_valid,
    output logic                      o_spike,
    output neuro_pkg::count_t         o_neuron_count,
    output neuro_pkg::count_t         o_ext_count
);
    import neuro_pkg::*;

    logic [`NEURO_PARAM_W-1:0] tick_div;
    logic [`NEURO_PARAM_W-1:0] gain;
    logic [`NEURO_PARAM_W-1:0] threshold;
    logic [`NEURO_PARAM_W-1:0] blk_size;
    logic [`NEURO_PARAM_W-1:0] syn_weight;

    // player side of the memory port
    logic                      play_req;
    logic [`NEURO_ADDR_W-1:0]  play_addr;
    logic                      play_grant;
    // loader side
    logic                      load_req;
    logic [`NEURO_ADDR_W-1:0]  load_addr;
    sample_t                   load_wdata;
    logic                      load_grant;
    sample_t                   mem_rdata;
    logic                      mem_rvalid;

    //////////////////////////////////////////////////////////////////////
    // host parameters
    //////////////////////////////////////////////////////////////////////
    param_bank param_bank_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_param_we     (i_param_we),
        .i_param_id     (i_param_id),
        .i_param_data   (i_param_data),
        .o_tick_div     (tick_div),
        .o_gain         (gain),
        .o_threshold    (threshold),
        .o_blk_size     (blk_size),
        .o_syn_weight   (syn_weight)
    );

    //////////////////////////////////////////////////////////////////////
    // sample memory and its two peers
    //////////////////////////////////////////////////////////////////////
    pipe_loader pipe_loader_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_pipe_valid   (i_pipe_valid),
        .i_pipe_data    (i_pipe_data),
        .o_pipe_ready   (o_pipe_ready),
        .o_mem_req      (load_req),
        .o_mem_addr     (load_addr),
        .o_mem_wdata    (load_wdata),
        .i_mem_grant    (load_grant)
    );

    wave_player wave_player_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_tick_div     (tick_div),
        .i_blk_size     (blk_size),
        .o_mem_req      (play_req),
        .o_mem_addr     (play_addr),
        .i_mem_grant    (play_grant),
        .i_mem_rdata    (mem_rdata),
        .i_mem_rvalid   (mem_rvalid),
        .o_wave_sample  (o_wave_sample),
        .o_wave_valid   (o_wave_valid)
    );

    wave_mem_arbiter wave_mem_arbiter_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_play_req     (play_req),
        .i_play_addr    (play_addr),
        .o_play_grant   (play_grant),
        .i_load_req     (load_req),
        .i_load_addr    (load_addr),
        .i_load_wdata   (load_wdata),
        .o_load_grant   (load_grant),
        .o_rdata        (mem_rdata),
        .o_rvalid       (mem_rvalid)
    );

    //////////////////////////////////////////////////////////////////////
    // neuron and spike counts
    //////////////////////////////////////////////////////////////////////
    lif_neuron lif_neuron_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_sample       (o_wave_sample),
        .i_sample_valid (o_wave_valid),
        .i_ext_spike    (i_ext_spike),
        .i_gain         (gain),
        .i_syn_weight   (syn_weight),
        .i_threshold    (threshold),
        .o_spike        (o_spike)
    );

    spike_counter spike_counter_i
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_neuron_spike (o_spike),
        .i_ext_spike    (i_ext_spike),
        .o_neuron_count (o_neuron_count),
        .o_ext_count    (o_ext_count)
    );

endmodule

// ==== param_bank.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module param_bank
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_param_we,
    input  neuro_pkg::param_id_e      i_param_id,
    input  logic [`NEURO_PARAM_W-1:0] i_param_data,
    output logic [`NEURO_PARAM_W-1:0] o_tick_div,
    output logic [`NEURO_PARAM_W-1:0] o_gain,
    output logic [`NEURO_PARAM_W-1:0] o_threshold,
    output logic [`NEURO_PARAM_W-1:0] o_blk_size,
    output logic [`NEURO_PARAM_W-1:0] o_syn_weight
);
    import neuro_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // trigger-style parameter writes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_tick_div   <= `NEURO_DEF_TICK_DIV;
            o_gain       <= `NEURO_DEF_GAIN;
            o_threshold  <= `NEURO_DEF_THRESHOLD;
            o_blk_size   <= `NEURO_DEF_BLK_SIZE;
            o_syn_weight <= `NEURO_DEF_SYN_WEIGHT;
        end
        else if (i_param_we)
        begin
            // one register per id, others untouched
            case (i_param_id)
                PARAM_TICK_DIV:   o_tick_div   <= i_param_data;
                PARAM_GAIN:       o_gain       <= i_param_data;
                PARAM_THRESHOLD:  o_threshold  <= i_param_data;
                PARAM_BLK_SIZE:   o_blk_size   <= i_param_data;
                PARAM_SYN_WEIGHT: o_syn_weight <= i_param_data;
                // undefined ids dropped
                default: ;
            endcase
        end
    end

    // host only ever targets a defined register
    a_known_id: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        i_param_we |-> (i_param_id inside {PARAM_TICK_DIV, PARAM_GAIN, PARAM_THRESHOLD,
                                           PARAM_BLK_SIZE, PARAM_SYN_WEIGHT}));

endmodule

// ==== pipe_loader.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module pipe_loader
(
    input  logic                     i_ep50trig,
    input  logic                     i_reset_global,
    input  logic                     i_sim_restart,
    input  logic                     i_pipe_valid,
    input  neuro_pkg::sample_t       i_pipe_data,
    output logic                     o_pipe_ready,
    output logic                     o_mem_req,
    output logic [`NEURO_ADDR_W-1:0] o_mem_addr,
    output neuro_pkg::sample_t       o_mem_wdata,
    input  logic                     i_mem_grant
);
    import neuro_pkg::*;

    logic [`NEURO_ADDR_W-1:0] wr_addr;
    load_state_e              load_state;

    // every offered word asks for a write slot
    assign o_mem_req    = i_pipe_valid;
    assign o_mem_addr   = wr_addr;
    assign o_mem_wdata  = i_pipe_data;
    // host sees the arbiter's slot directly
    assign o_pipe_ready = i_mem_grant;

    // write pointer, wraps at the memory depth
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_sim_restart)
            wr_addr <= '0;
        else if (i_pipe_valid && i_mem_grant)
            wr_addr <= wr_addr + 1'b1;
    end

    // LOAD_WRITE marks a word left pending by a stall
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            load_state <= LOAD_IDLE;
        else if (i_pipe_valid && !i_mem_grant)
            load_state <= LOAD_WRITE;
        else
            load_state <= LOAD_IDLE;
    end

    // a stalled word stays offered and unchanged
    a_hold_data: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        (load_state == LOAD_WRITE) |-> (i_pipe_valid && i_pipe_data == $past(i_pipe_data)));

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build the neuron rig testbench with Verilator, run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
# a failed build or an aborted run also counts as a failure
verilator --binary --timing --assert -Wno-fatal --top-module tb_neuro -f list.f \
    && ./obj_dir/Vtb_neuro > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
# verdict from the log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== spike_counter.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module spike_counter
(
    input  logic              i_ep50trig,
    input  logic              i_reset_global,
    input  logic              i_sim_restart,
    input  logic              i_neuron_spike,
    input  logic              i_ext_spike,
    output neuro_pkg::count_t o_neuron_count,
    output neuro_pkg::count_t o_ext_count
);
    logic ext_d;
    logic ext_rise;

    // delayed copy for edge detect
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            ext_d <= 1'b0;
        else
            ext_d <= i_ext_spike;
    end

    assign ext_rise = i_ext_spike && !ext_d;

    // both counters stick at all ones
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_sim_restart)
        begin
            o_neuron_count <= '0;
            o_ext_count    <= '0;
        end
        else
        begin
            if (i_neuron_spike && o_neuron_count != '1)
                o_neuron_count <= o_neuron_count + 1'b1;
            if (ext_rise && o_ext_count != '1)
                o_ext_count <= o_ext_count + 1'b1;
        end
    end

endmodule

// ==== tb_neuro.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module tb_neuro;
    import neuro_pkg::*;

    // sum of all phases is about 1400 cycles
    localparam int MAX_CYCLES = 4000;
    localparam int N_WORDS    = 16;

    logic                      ep50trig;
    logic                      reset_global;
    logic                      i_sim_restart;
    logic                      i_param_we;
    param_id_e                 i_param_id;
    logic [`NEURO_PARAM_W-1:0] i_param_data;
    logic                      i_pipe_valid;
    sample_t                   i_pipe_data;
    logic                      o_pipe_ready;
    logic                      i_ext_spike;
    sample_t                   o_wave_sample;
    logic                      o_wave_valid;
    logic                      o_spike;
    count_t                    o_neuron_count;
    count_t                    o_ext_count;

    // reference model state
    sample_t                   exp_mem [`NEURO_MEM_DEPTH];
    sample_t                   exp_sample;
    logic [`NEURO_ADDR_W-1:0]  m_wr_addr;
    logic [`NEURO_ADDR_W-1:0]  m_rd_addr;
    logic [31:0]               m_tick;
    logic [31:0]               m_gain;
    logic [31:0]               m_th;
    logic [31:0]               m_blk;
    logic [31:0]               m_w;
    logic [31:0]               m_v;
    logic [31:0]               m_cur;
    logic [31:0]               m_v_next;
    logic                      m_spike;
    count_t                    m_ncount;
    count_t                    m_ext;
    logic                      m_ext_prev;
    logic [31:0]               m_gap;
    logic                      m_seen;

    sample_t                   load_words [N_WORDS];
    logic [31:0]               rng_state;
    logic                      ext_en;
    logic                      check_play;
    string                     test_name;
    int                        test_no;
    int                        test_errs;
    int                        n_pass;
    int                        n_fail;
    int                        cycle_cnt;
    int                        stalls;
    int                        idx;
    count_t                    cnt_lo;
    count_t                    cnt_hi;

    neuro_top dut_i
    (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_sim_restart  (i_sim_restart),
        .i_param_we     (i_param_we),
        .i_param_id     (i_param_id),
        .i_param_data   (i_param_data),
        .i_pipe_valid   (i_pipe_valid),
        .i_pipe_data    (i_pipe_data),
        .o_pipe_ready   (o_pipe_ready),
        .i_ext_spike    (i_ext_spike),
        .o_wave_sample  (o_wave_sample),
        .o_wave_valid   (o_wave_valid),
        .o_spike        (o_spike),
        .o_neuron_count (o_neuron_count),
        .o_ext_count    (o_ext_count)
    );

    // 100 ns period
    always #50 ep50trig = !ep50trig;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_value(input string what, input longint expv, input longint actv);
        $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expv, actv);
        test_errs++;
    endtask

    task automatic report_text(input string msg);
        $display("error in %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_no++;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0)
        begin
            $display("[%0d] %s: PASS", test_no, test_name);
            n_pass++;
        end
        else
        begin
            $display("[%0d] %s: FAIL, %0d errors", test_no, test_name, test_errs);
            n_fail++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    // parameter registers as the host wrote them
    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            m_tick <= `NEURO_DEF_TICK_DIV;
            m_gain <= `NEURO_DEF_GAIN;
            m_th   <= `NEURO_DEF_THRESHOLD;
            m_blk  <= `NEURO_DEF_BLK_SIZE;
            m_w    <= `NEURO_DEF_SYN_WEIGHT;
        end
        else if (i_param_we)
        begin
            case (i_param_id)
                PARAM_TICK_DIV:   m_tick <= i_param_data;
                PARAM_GAIN:       m_gain <= i_param_data;
                PARAM_THRESHOLD:  m_th   <= i_param_data;
                PARAM_BLK_SIZE:   m_blk  <= i_param_data;
                PARAM_SYN_WEIGHT: m_w    <= i_param_data;
                default: ;
            endcase
        end
    end

    assign exp_sample = exp_mem[m_rd_addr];

    always @(posedge ep50trig)
    begin
        if (reset_global || i_sim_restart)
        begin
            m_wr_addr <= '0;
            m_rd_addr <= '0;
            m_v       <= '0;
            m_spike   <= 1'b0;
            m_ncount  <= '0;
            m_ext     <= '0;
            m_gap     <= '0;
            m_seen    <= 1'b0;
        end
        else
        begin
            // host transfer lands at the next write slot
            if (i_pipe_valid && o_pipe_ready)
            begin
                exp_mem[m_wr_addr] <= i_pipe_data;
                m_wr_addr          <= m_wr_addr + 1'b1;
            end
            if (o_wave_valid)
            begin
                // gain in 8.8, leak by v/16, kick while ext high
                m_cur    = 32'((64'(exp_sample) * 64'(m_gain)) >> 8);
                m_v_next = m_v - (m_v >> `NEURO_LEAK_SHIFT) + m_cur
                           + (i_ext_spike ? m_w : 32'd0);
                if (m_v_next >= m_th)
                begin
                    m_v     <= '0;
                    m_spike <= 1'b1;
                end
                else
                begin
                    m_v     <= m_v_next;
                    m_spike <= 1'b0;
                end
                // read pointer steps modulo blk_size
                if (32'(m_rd_addr) + 32'd1 >= m_blk)
                    m_rd_addr <= '0;
                else
                    m_rd_addr <= m_rd_addr + 1'b1;
                m_gap  <= 32'd1;
                m_seen <= 1'b1;
            end
            else
            begin
                m_spike <= 1'b0;
                m_gap   <= m_gap + 32'd1;
            end
            if (m_spike && m_ncount != '1)
                m_ncount <= m_ncount + 1'b1;
            if (i_ext_spike && !m_ext_prev && m_ext != '1)
                m_ext <= m_ext + 1'b1;
        end
        m_ext_prev <= reset_global ? 1'b0 : i_ext_spike;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_reset_state: assert property (@(posedge ep50trig)
        $fell(reset_global) |-> (!o_spike && !o_wave_valid && o_neuron_count == '0
                                 && o_ext_count == '0 && o_pipe_ready))
        else report_text("outputs were not idle right after reset");

    // ready drops only in the tick cycle
    a_ready_low: assert property (@(posedge ep50trig) disable iff (reset_global)
        !o_pipe_ready |=> o_wave_valid)
        else report_text("ready went low without a sample one cycle later");

    a_valid_after_tick: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_wave_valid |-> !$past(o_pipe_ready))
        else report_text("sample arrived without ready low the cycle before");

    a_wr_count: assert property (@(posedge ep50trig) disable iff (reset_global)
        dut_i.pipe_loader_i.wr_addr == m_wr_addr)
        else report_value("accepted words", $sampled(m_wr_addr),
                          $sampled(dut_i.pipe_loader_i.wr_addr));

    a_sample: assert property (@(posedge ep50trig) disable iff (reset_global)
        (check_play && o_wave_valid) |-> o_wave_sample == exp_sample)
        else report_value("wave sample", $sampled(exp_sample), $sampled(o_wave_sample));

    a_gap: assert property (@(posedge ep50trig) disable iff (reset_global)
        (o_wave_valid && m_seen) |-> m_gap == m_tick)
        else report_value("sample spacing", $sampled(m_tick), $sampled(m_gap));

    a_spike: assert property (@(posedge ep50trig) disable iff (reset_global)
        check_play |-> o_spike == m_spike)
        else report_value("spike", $sampled(m_spike), $sampled(o_spike));

    a_ncount: assert property (@(posedge ep50trig) disable iff (reset_global)
        check_play |-> o_neuron_count == m_ncount)
        else report_value("neuron count", $sampled(m_ncount), $sampled(o_neuron_count));

    a_ext: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_ext_count == m_ext)
        else report_value("ext count", $sampled(m_ext), $sampled(o_ext_count));

    a_restart_clear: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_sim_restart |=> (o_neuron_count == '0 && o_ext_count == '0))
        else report_text("counts did not clear after restart");

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    // random ext line, new level each cycle
    always @(negedge ep50trig)
    begin
        if (ext_en)
        begin
            rng_state   = xorshift32(rng_state);
            i_ext_spike = rng_state[3];
        end
    end

    task automatic write_param(input param_id_e id, input logic [31:0] data);
        @(negedge ep50trig);
        i_param_we   = 1'b1;
        i_param_id   = id;
        i_param_data = data;
        @(negedge ep50trig);
        i_param_we   = 1'b0;
    endtask

    // restart only in a slot with no tick and no sample pending
    task automatic restart_sim();
        @(negedge ep50trig);
        while (!o_pipe_ready || o_wave_valid)
            @(negedge ep50trig);
        i_sim_restart = 1'b1;
        @(negedge ep50trig);
        i_sim_restart = 1'b0;
        check_play    = 1'b1;
    endtask

    task automatic stream_words();
        int  sent;
        logic took;
        sent   = 0;
        stalls = 0;
        @(negedge ep50trig);
        i_pipe_valid = 1'b1;
        i_pipe_data  = load_words[0];
        while (sent < N_WORDS)
        begin
            // ready is stable until the next edge
            took = o_pipe_ready;
            @(negedge ep50trig);
            if (took)
            begin
                sent++;
                if (sent < N_WORDS)
                    i_pipe_data = load_words[sent];
                else
                    i_pipe_valid = 1'b0;
            end
            else
                stalls++;
        end
    endtask

    task automatic wait_samples(input int n);
        int seen;
        seen = 0;
        while (seen < n)
        begin
            @(negedge ep50trig);
            if (o_wave_valid)
                seen++;
        end
        // let spike and count catch up
        repeat (3) @(negedge ep50trig);
    endtask

    // watchdog
    always @(posedge ep50trig)
    begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, samples stopped arriving", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        ep50trig      = 1'b0;
        reset_global  = 1'b1;
        i_sim_restart = 1'b0;
        i_param_we    = 1'b0;
        i_param_id    = PARAM_TICK_DIV;
        i_param_data  = '0;
        i_pipe_valid  = 1'b0;
        i_pipe_data   = '0;
        i_ext_spike   = 1'b0;
        ext_en        = 1'b0;
        check_play    = 1'b0;
        rng_state     = 32'd27;
        test_no       = 0;
        test_errs     = 0;
        n_pass        = 0;
        n_fail        = 0;
        cycle_cnt     = 0;
        // samples 200..1099, enough drive to cross 4000
        for (idx = 0; idx < N_WORDS; idx++)
        begin
            rng_state       = xorshift32(rng_state);
            load_words[idx] = 16'(rng_state % 900) + 16'd200;
        end

        start_test("reset_state");
        repeat (3) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
        repeat (2) @(negedge ep50trig);
        finish_test();

        start_test("load_backpressure");
        stream_words();
        assert (stalls > 0)
        else report_text("no word was stalled by a tick");
        finish_test();

        start_test("playback_wrap");
        write_param(PARAM_BLK_SIZE, 32'd16);
        restart_sim();
        wait_samples(20);
        finish_test();

        start_test("neuron_threshold");
        restart_sim();
        wait_samples(40);
        cnt_lo = o_neuron_count;
        // peak membrane stays below this
        write_param(PARAM_THRESHOLD, 32'd20000);
        restart_sim();
        wait_samples(40);
        cnt_hi = o_neuron_count;
        assert (cnt_lo > 0 && cnt_hi < cnt_lo)
        else report_text($sformatf("higher threshold did not lower spikes (%0d then %0d)",
                                   cnt_lo, cnt_hi));
        write_param(PARAM_THRESHOLD, `NEURO_DEF_THRESHOLD);
        finish_test();

        start_test("ext_spikes_syn_weight");
        write_param(PARAM_SYN_WEIGHT, 32'd1500);
        restart_sim();
        ext_en = 1'b1;
        wait_samples(40);
        assert (o_ext_count > 0)
        else report_text("no external edges reached the counter");
        finish_test();

        start_test("restart");
        restart_sim();
        wait_samples(20);
        ext_en      = 1'b0;
        i_ext_spike = 1'b0;
        finish_test();

        $display("summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== wave_mem_arbiter.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module wave_mem_arbiter
(
    input  logic                     i_ep50trig,
    input  logic                     i_reset_global,
    input  logic                     i_play_req,
    input  logic [`NEURO_ADDR_W-1:0] i_play_addr,
    output logic                     o_play_grant,
    input  logic                     i_load_req,
    input  logic [`NEURO_ADDR_W-1:0] i_load_addr,
    input  neuro_pkg::sample_t       i_load_wdata,
    output logic                     o_load_grant,
    output neuro_pkg::sample_t       o_rdata,
    output logic                     o_rvalid
);
    import neuro_pkg::*;

    sample_t    mem [`NEURO_MEM_DEPTH];
    arb_owner_e owner;

    //////////////////////////////////////////////////////////////////////
    // fixed priority, player first
    //////////////////////////////////////////////////////////////////////
    assign o_play_grant = i_play_req;
    // load slot offered whenever the player is quiet
    assign o_load_grant = !i_play_req;

    // sample array, single port
    always_ff @(posedge i_ep50trig)
    begin
        if (o_play_grant)
            o_rdata <= mem[i_play_addr];
        else if (i_load_req && o_load_grant)
            mem[i_load_addr] <= i_load_wdata;
    end

    // owner of the slot just used
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            owner <= OWN_NONE;
        else if (o_play_grant)
            owner <= OWN_PLAYER;
        else if (i_load_req && o_load_grant)
            owner <= OWN_LOADER;
        else
            owner <= OWN_NONE;
    end

    // read data valid only behind a player slot
    assign o_rvalid = (owner == OWN_PLAYER);

    // one owner per cycle
    a_one_grant: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        !(o_play_grant && o_load_grant));

endmodule

// ==== wave_player.sv ====
`timescale 1ns/10ps
`include "neuro_settings.svh"

module wave_player
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_sim_restart,
    input  logic [`NEURO_PARAM_W-1:0] i_tick_div,
    input  logic [`NEURO_PARAM_W-1:0] i_blk_size,
    output logic                      o_mem_req,
    output logic [`NEURO_ADDR_W-1:0]  o_mem_addr,
    input  logic                      i_mem_grant,
    input  neuro_pkg::sample_t        i_mem_rdata,
    input  logic                      i_mem_rvalid,
    output neuro_pkg::sample_t        o_wave_sample,
    output logic                      o_wave_valid
);
    logic [`NEURO_PARAM_W-1:0] tick_cnt;
    logic [`NEURO_PARAM_W-1:0] tick_cnt_next;
    logic                      tick;
    logic [`NEURO_ADDR_W-1:0]  rd_addr;
    logic [`NEURO_PARAM_W-1:0] rd_addr_next;

    //////////////////////////////////////////////////////////////////////
    // tick divider
    //////////////////////////////////////////////////////////////////////
    assign tick_cnt_next = tick_cnt + `NEURO_PARAM_W'(1);

    // one registered tick every tick_div cycles
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_sim_restart)
        begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end
        else if (tick_cnt_next >= i_tick_div)
        begin
            tick_cnt <= '0;
            tick     <= 1'b1;
        end
        else
        begin
            tick_cnt <= tick_cnt_next;
            tick     <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sample fetch
    //////////////////////////////////////////////////////////////////////
    assign o_mem_req  = tick;
    assign o_mem_addr = rd_addr;

    // next address, widened to compare against blk_size
    assign rd_addr_next = {{(`NEURO_PARAM_W-`NEURO_ADDR_W){1'b0}}, rd_addr}
                          + `NEURO_PARAM_W'(1);

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_sim_restart)
            rd_addr <= '0;
        else if (tick && i_mem_grant)
        begin
            // wrap at the end of the block
            if (rd_addr_next >= i_blk_size)
                rd_addr <= '0;
            else
                rd_addr <= rd_addr_next[`NEURO_ADDR_W-1:0];
        end
    end

    // arbiter read data lands one cycle after the tick
    assign o_wave_sample = i_mem_rdata;
    assign o_wave_valid  = i_mem_rvalid;

    // player has priority so it is never refused
    a_req_granted: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        o_mem_req |-> i_mem_grant);

endmodule
